// ==== compile.f ====
+incdir+hw
hw/isa_pkg.sv
hw/pipe_pkg.sv
hw/reg_file.sv
hw/fetch_stage.sv
hw/decode_stage.sv
hw/control_unit.sv
hw/execute_stage.sv
hw/memory_stage.sv
hw/pipeline.sv
test/tb_pipeline.sv

// ==== Makefile ====
# Verilator build and run of the pipeline testbench
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check $(LOG) for the pass line"
	@echo "  clean  remove obj_dir and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --timing --top-module tb_pipeline -f compile.f -Mdir obj_dir -o tb_pipeline
	./obj_dir/tb_pipeline | tee $(LOG)
	@grep -q "TEST RESULT: PASS" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

// ==== test/tb_pipeline.sv ====
`include "cpu_config.svh"

module tb_pipeline
    import isa_pkg::*, pipe_pkg::*;
();

    localparam int RESET_CYCLES = 16;
    // Cycle limit for one program after reset
    localparam int RUN_LIMIT = 300;
    localparam int TEST_COUNT = 5;
    // All tests with their resets plus some slack
    localparam int WATCHDOG_CYCLES = TEST_COUNT * (RESET_CYCLES + RUN_LIMIT + 8);
    // A store here ends a program
    localparam word_t SENTINEL = 32'h0000_0ffc;

    logic      clk = 1'b0;
    logic      arst_n;
    word_t     imem_addr;
    instr_u    imem_data;
    dmem_req_t dmem_req;
    word_t     dmem_rdata;

    // Instruction ROM and data RAM with combinational reads
    instr_u rom [256];
    word_t  dmem [1024];

    // Program being built with its register model and store records
    instr_u prog [$];
    word_t  model [32];
    word_t  exp_addr [$];
    word_t  exp_data [$];
    word_t  got_addr [$];
    word_t  got_data [$];

    word_t rng = 32'h9d9b_ff82;
    int    errors = 0;
    int    tests_run = 0;
    int    tests_failed = 0;

    always #5 clk = ~clk;

    assign imem_data  = rom[imem_addr[9:2]];
    // Read data only while the read strobe is up
    assign dmem_rdata = dmem_req.re ? dmem[dmem_req.addr[11:2]] : '0;

    pipeline DUT (
        .clk        (clk),
        .arst_n     (arst_n),
        .imem_addr  (imem_addr),
        .imem_data  (imem_data),
        .dmem_req   (dmem_req),
        .dmem_rdata (dmem_rdata)
    );

    ////////////////////
    // Helpers
    ////////////////////

    function automatic word_t xorshift32();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    // Background data derived from the full byte address
    function automatic word_t fill_word(input word_t addr);
        return (addr * 32'h9e37_79b9) ^ {addr[15:0], addr[31:16]} ^ 32'h5bd1_e995;
    endfunction

    function automatic instr_u enc_r(input funct_e fn, input reg_addr_t rd,
                                     input reg_addr_t rs, input reg_addr_t rt);
        instr_u w;
        w.r.opcode = OP_RTYPE;
        w.r.rs     = rs;
        w.r.rt     = rt;
        w.r.rd     = rd;
        w.r.shamt  = '0;
        w.r.funct  = fn;
        return w;
    endfunction

    function automatic instr_u enc_i(input opcode_e op, input reg_addr_t rt,
                                     input reg_addr_t rs, input logic [15:0] imm);
        instr_u w;
        w.i.opcode = op;
        w.i.rs     = rs;
        w.i.rt     = rt;
        w.i.imm    = imm;
        return w;
    endfunction

    // Word index of the target inside the 256 MB region
    function automatic instr_u enc_j(input word_t addr);
        instr_u w;
        w.j.opcode = OP_J;
        w.j.target = addr[27:2];
        return w;
    endfunction

    // R-format results by the ISA rules
    function automatic word_t alu_ref(input funct_e fn, input word_t a, input word_t b);
        case (fn)
            FN_ADDU: return a + b;
            FN_SUBU: return a - b;
            FN_AND:  return a & b;
            FN_OR:   return a | b;
            FN_XOR:  return a ^ b;
            default: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        endcase
    endfunction

    // Immediate forms where logical ops zero extend
    function automatic word_t imm_ref(input opcode_e op, input word_t a, input logic [15:0] imm);
        case (op)
            OP_ADDIU: return a + {{16{imm[15]}}, imm};
            OP_ANDI:  return a & {16'h0000, imm};
            OP_ORI:   return a | {16'h0000, imm};
            default:  return {imm, 16'h0000};
        endcase
    endfunction

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("ERR t=%0t %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    ////////////////////
    // Program building
    ////////////////////

    task automatic new_prog();
        prog.delete();
        exp_addr.delete();
        exp_data.delete();
        model = '{default: '0};
    endtask

    task automatic op_r(input funct_e fn, input reg_addr_t rd, input reg_addr_t rs,
                        input reg_addr_t rt);
        prog.push_back(enc_r(fn, rd, rs, rt));
        if (rd != '0) begin
            model[rd] = alu_ref(fn, model[rs], model[rt]);
        end
    endtask

    task automatic op_i(input opcode_e op, input reg_addr_t rt, input reg_addr_t rs,
                        input logic [15:0] imm);
        prog.push_back(enc_i(op, rt, rs, imm));
        if (rt != '0) begin
            model[rt] = imm_ref(op, model[rs], imm);
        end
    endtask

    // Full word constant built by lui then ori
    task automatic li(input reg_addr_t rd, input word_t v);
        op_i(OP_LUI, rd, '0, v[31:16]);
        op_i(OP_ORI, rd, rd, v[15:0]);
    endtask

    task automatic st(input reg_addr_t rt, input word_t addr);
        prog.push_back(enc_i(OP_SW, rt, '0, addr[15:0]));
        exp_addr.push_back(addr);
        exp_data.push_back(model[rt]);
    endtask

    task automatic ld(input reg_addr_t rt, input word_t addr, input word_t value);
        prog.push_back(enc_i(OP_LW, rt, '0, addr[15:0]));
        if (rt != '0) begin
            model[rt] = value;
        end
    endtask

    // Instruction that must be squashed and so leaves the model untouched
    task automatic skip(input reg_addr_t rt, input logic [15:0] imm);
        prog.push_back(enc_i(OP_ADDIU, rt, rt, imm));
    endtask

    task automatic br(input opcode_e op, input reg_addr_t rs, input reg_addr_t rt,
                      input logic [15:0] off);
        prog.push_back(enc_i(op, rt, rs, off));
    endtask

    task automatic end_prog();
        prog.push_back(enc_i(OP_SW, '0, '0, SENTINEL[15:0]));
    endtask

    ////////////////////
    // Running a program
    ////////////////////

    task automatic start_run();
        for (int i = 0; i < 256; i++) begin
            rom[8'(i)] = (i < prog.size()) ? prog[i] : INSTR_NOP;
        end
        for (int i = 0; i < 1024; i++) begin
            dmem[10'(i)] = fill_word(word_t'(i) << 2);
        end
        got_addr.delete();
        got_data.delete();
        @(negedge clk);
        arst_n = 1'b0;
        // No strobes and a parked PC during reset
        repeat (RESET_CYCLES) begin
            @(negedge clk);
            check_word("dmem_req.we", word_t'(dmem_req.we), '0);
            check_word("dmem_req.re", word_t'(dmem_req.re), '0);
            check_word("imem_addr", imem_addr, `RESET_PC);
        end
        arst_n = 1'b1;
    endtask

    // Record stores mid-cycle until the sentinel store
    task automatic wait_done(input string name);
        int   cycles;
        logic done;
        cycles = 0;
        done   = 1'b0;
        while (!done && cycles < RUN_LIMIT) begin
            @(negedge clk);
            cycles++;
            if (dmem_req.we) begin
                if (dmem_req.addr == SENTINEL) begin
                    done = 1'b1;
                end else begin
                    got_addr.push_back(dmem_req.addr);
                    got_data.push_back(dmem_req.wdata);
                    dmem[dmem_req.addr[11:2]] = dmem_req.wdata;
                end
            end
        end
        if (!done) begin
            $display("%s: no store to the end address within %0d cycles", name, RUN_LIMIT);
            errors++;
        end
    endtask

    task automatic check_stores();
        int n;
        if (got_addr.size() != exp_addr.size()) begin
            $display("ERR t=%0t store count got %0d expected %0d", $time,
                     got_addr.size(), exp_addr.size());
            errors++;
        end
        n = (got_addr.size() < exp_addr.size()) ? got_addr.size() : exp_addr.size();
        for (int i = 0; i < n; i++) begin
            check_word($sformatf("dmem_req.addr (store %0d)", i), got_addr[i], exp_addr[i]);
            check_word($sformatf("dmem_req.wdata (store %0d)", i), got_data[i], exp_data[i]);
        end
    endtask

    task automatic end_test(input string name, input int errs_at_start);
        tests_run++;
        if (errors == errs_at_start) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: failed, %0d errors", name, errors - errs_at_start);
        end
    endtask

    ////////////////////
    // Tests
    ////////////////////

    task automatic test_reset();
        int errs;
        errs = errors;
        new_prog();
        op_i(OP_ADDIU, 1, 0, 16'h005a);
        st(1, 32'h240);
        end_prog();
        start_run();
        check_word("imem_addr", imem_addr, `RESET_PC);
        // First store cannot reach MEM for three more edges
        repeat (3) begin
            @(negedge clk);
            check_word("dmem_req.we", word_t'(dmem_req.we), '0);
            check_word("dmem_req.re", word_t'(dmem_req.re), '0);
        end
        wait_done("reset");
        check_stores();
        end_test("reset", errs);
    endtask

    // Back-to-back dependencies forwarded from both stages
    task automatic test_alu_chain();
        int          errs;
        word_t       rnd;
        logic [15:0] k;
        errs = errors;
        new_prog();
        for (int round = 0; round < 3; round++) begin
            rnd = xorshift32();
            k   = rnd[15:0];
            li(1, xorshift32());
            li(2, xorshift32());
            op_r(FN_ADDU, 3, 1, 2);
            op_r(FN_SUBU, 4, 3, 1);
            op_r(FN_XOR, 5, 4, 3);
            op_r(FN_AND, 6, 5, 2);
            op_r(FN_OR, 7, 6, 4);
            op_r(FN_SLT, 8, 7, 1);
            op_r(FN_SLT, 9, 1, 7);
            op_i(OP_ADDIU, 10, 7, k);
            op_i(OP_ANDI, 11, 10, ~k);
            op_i(OP_ORI, 12, 11, k ^ 16'h0ff0);
            for (int r = 3; r <= 12; r++) begin
                st(5'(r), word_t'(32'h100 + round * 64 + r * 4));
            end
        end
        end_prog();
        start_run();
        wait_done("alu_chain");
        check_stores();
        end_test("alu_chain", errs);
    endtask

    task automatic test_load_use();
        int    errs;
        word_t v;
        errs = errors;
        new_prog();
        v = xorshift32();
        li(1, v);
        st(1, 32'h200);
        li(2, xorshift32());
        // Loaded value used by the very next instruction
        ld(3, 32'h200, v);
        op_r(FN_ADDU, 4, 3, 2);
        st(4, 32'h210);
        ld(5, 32'h300, fill_word(32'h300));
        st(5, 32'h214);
        ld(6, 32'h304, fill_word(32'h304));
        op_i(OP_ADDIU, 7, 6, 16'h0001);
        op_r(FN_SUBU, 8, 2, 6);
        st(7, 32'h218);
        st(8, 32'h21c);
        end_prog();
        start_run();
        wait_done("load_use");
        check_stores();
        end_test("load_use", errs);
    endtask

    // Marker bits in $5 show which path ran
    task automatic test_branches();
        int    errs;
        word_t x;
        errs = errors;
        new_prog();
        x = xorshift32();
        op_i(OP_ADDIU, 5, 0, 16'h0001);
        li(3, ~x);
        li(1, x);
        li(2, x);
        br(OP_BEQ, 1, 2, 16'd2);
        skip(5, 16'h0010);
        skip(5, 16'h0020);
        op_i(OP_ADDIU, 5, 5, 16'h0100);
        br(OP_BNE, 1, 3, 16'd2);
        skip(5, 16'h0200);
        skip(5, 16'h0400);
        br(OP_BEQ, 1, 3, 16'd1);
        op_i(OP_ADDIU, 5, 5, 16'h0800);
        br(OP_BNE, 1, 2, 16'd1);
        op_i(OP_ADDIU, 5, 5, 16'h1000);
        // Compare on a value still in the load stall
        li(6, fill_word(32'h308));
        ld(4, 32'h308, fill_word(32'h308));
        br(OP_BEQ, 4, 6, 16'd2);
        skip(5, 16'h4000);
        skip(5, 16'h4000);
        op_i(OP_ADDIU, 5, 5, 16'h2000);
        st(5, 32'h220);
        end_prog();
        start_run();
        wait_done("branches");
        check_stores();
        end_test("branches", errs);
    endtask

    task automatic test_jump_zero();
        int errs;
        errs = errors;
        new_prog();
        op_i(OP_ADDIU, 6, 0, 16'h0011);
        // Target is two words past the jump
        prog.push_back(enc_j(word_t'((prog.size() + 2) * 4)));
        skip(6, 16'h0022);
        op_i(OP_ADDIU, 6, 6, 16'h0044);
        op_i(OP_ADDIU, 0, 0, 16'h0055);
        op_r(FN_ADDU, 7, 0, 6);
        op_i(OP_LUI, 0, 0, 16'h1234);
        op_r(FN_OR, 8, 0, 0);
        st(0, 32'h230);
        st(7, 32'h234);
        st(8, 32'h238);
        st(6, 32'h23c);
        end_prog();
        start_run();
        wait_done("jump_zero");
        check_stores();
        end_test("jump_zero", errs);
    endtask

    ////////////////////
    // Main sequence and watchdog
    ////////////////////

    initial begin
        arst_n = 1'b0;
        test_reset();
        test_alu_chain();
        test_load_use();
        test_branches();
        test_jump_zero();
        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * 10);
        $display("Watchdog expired after %0d cycles, run stopped", WATCHDOG_CYCLES);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

// ==== hw/pipeline.sv ====
module pipeline
    import isa_pkg::*, pipe_pkg::*;
(
    input  logic      clk,
    input  logic      arst_n,
    output word_t     imem_addr,
    input  instr_u    imem_data,
    output dmem_req_t dmem_req,
    input  word_t     dmem_rdata
);

    // Stage registers
    if_id_t  if_id;
    id_ex_t  id_ex;
    ex_mem_t ex_mem;
    wb_t     wb;

    // ID outputs
    logic      jump;
    word_t     jump_target;
    reg_addr_t id_rs;
    reg_addr_t id_rt;

    // EX outputs
    logic  branch_taken;
    word_t branch_target;

    // Control unit outputs
    pc_src_e  pc_src;
    logic     stall;
    logic     flush_ifid;
    logic     flush_idex;
    fwd_sel_e fwd_a;
    fwd_sel_e fwd_b;

    fetch_stage u_fetch (.*);

    decode_stage u_decode (.*);

    execute_stage u_execute (.*);

    memory_stage u_memory (.*);

    // Hazards seen from ID/EX
    control_unit u_control (
        .idex_dest  (id_ex.dest),
        .idex_mem_r (id_ex.ctrl.mem_r),
        .idex_rs    (id_ex.rs),
        .idex_rt    (id_ex.rt),
        .*
    );

endmodule

// ==== hw/memory_stage.sv ====
module memory_stage
    import pipe_pkg::*;
(
    input  logic      clk,
    input  logic      arst_n,
    input  ex_mem_t   ex_mem,
    output dmem_req_t dmem_req,
    input  word_t     dmem_rdata,
    output wb_t       wb
);

    // Word access at the ALU address
    always_comb begin
        dmem_req.re    = ex_mem.mem_r;
        dmem_req.we    = ex_mem.mem_w;
        dmem_req.addr  = ex_mem.result;
        dmem_req.wdata = ex_mem.store_data;
    end

    ////////////////////
    // MEM/WB
    ////////////////////

    // Writeback data picked before the register, read data is same-cycle
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wb <= '0;
        end else begin
            wb.reg_w <= ex_mem.reg_w;
            wb.dest  <= ex_mem.dest;
            wb.data  <= ex_mem.mem_r ? dmem_rdata : ex_mem.result;
        end
    end

endmodule

// ==== hw/execute_stage.sv ====
module execute_stage
    import isa_pkg::*, pipe_pkg::*;
(
    input  logic     clk,
    input  logic     arst_n,
    input  id_ex_t   id_ex,
    input  fwd_sel_e fwd_a,
    input  fwd_sel_e fwd_b,
    input  wb_t      wb,
    output ex_mem_t  ex_mem,
    output logic     branch_taken,
    output word_t    branch_target
);

    word_t rs_fwd;
    word_t rt_fwd;
    word_t op_b;
    word_t alu_out;

    // Operand forwarding
    function automatic word_t fwd_mux(input fwd_sel_e sel, input word_t reg_val);
        case (sel)
            FWD_EXMEM: return ex_mem.result;
            FWD_MEMWB: return wb.data;
            default:   return reg_val;
        endcase
    endfunction

    always_comb begin
        rs_fwd = fwd_mux(fwd_a, id_ex.rs_val);
        rt_fwd = fwd_mux(fwd_b, id_ex.rt_val);
    end

    assign op_b = id_ex.ctrl.b_imm ? id_ex.imm : rt_fwd;

    ////////////////////
    // ALU
    ////////////////////

    always_comb begin
        case (id_ex.ctrl.alu_op)
            ALU_ADD:    alu_out = rs_fwd + op_b;
            ALU_SUB:    alu_out = rs_fwd - op_b;
            ALU_AND:    alu_out = rs_fwd & op_b;
            ALU_OR:     alu_out = rs_fwd | op_b;
            ALU_XOR:    alu_out = rs_fwd ^ op_b;
            // Signed compare, result 0 or 1
            ALU_SLT:    alu_out = word_t'($signed(rs_fwd) < $signed(op_b));
            ALU_PASS_B: alu_out = op_b;
            default:    alu_out = '0;
        endcase
    end

    // Branch resolved here, predicted not taken in IF
    assign branch_taken  = id_ex.ctrl.branch
                           && ((rs_fwd == rt_fwd) != id_ex.ctrl.branch_ne);
    assign branch_target = id_ex.pc_4 + {id_ex.imm[29:0], 2'b00};

    ////////////////////
    // EX/MEM
    ////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ex_mem <= '0;
        end else begin
            ex_mem.reg_w      <= id_ex.ctrl.reg_w;
            ex_mem.mem_r      <= id_ex.ctrl.mem_r;
            ex_mem.mem_w      <= id_ex.ctrl.mem_w;
            ex_mem.dest       <= id_ex.dest;
            ex_mem.result     <= alu_out;
            ex_mem.store_data <= rt_fwd;
        end
    end

endmodule

// ==== hw/control_unit.sv ====
module control_unit
    import pipe_pkg::*;
(
    input  reg_addr_t id_rs,
    input  reg_addr_t id_rt,
    input  logic      jump,
    input  reg_addr_t idex_dest,
    input  logic      idex_mem_r,
    input  reg_addr_t idex_rs,
    input  reg_addr_t idex_rt,
    input  logic      branch_taken,
    input  ex_mem_t   ex_mem,
    input  wb_t       wb,
    output pc_src_e   pc_src,
    output logic      stall,
    output logic      flush_ifid,
    output logic      flush_idex,
    output fwd_sel_e  fwd_a,
    output fwd_sel_e  fwd_b
);

    logic load_use;
    logic take_jump;

    ////////////////////
    // Hazards and PC
    ////////////////////

    // Load in EX feeding the word in ID
    assign load_use = idex_mem_r && idex_dest != '0
                      && (idex_dest == id_rs || idex_dest == id_rt);

    // A jump waits out a stall, the held word redecodes
    assign take_jump = jump && !load_use;

    // Taken branch squashes the stalled word too
    assign stall      = load_use && !branch_taken;
    assign flush_ifid = branch_taken || take_jump;
    assign flush_idex = branch_taken;

    always_comb begin
        if (branch_taken) begin
            pc_src = PC_BRANCH;
        end else if (take_jump) begin
            pc_src = PC_JUMP;
        end else begin
            pc_src = PC_SEQ;
        end
    end

    ////////////////////
    // Forwarding
    ////////////////////

    // Younger producer first, $0 never forwarded
    function automatic fwd_sel_e pick_src(input reg_addr_t src);
        if (src == '0) begin
            return FWD_NONE;
        end
        if (ex_mem.reg_w && ex_mem.dest == src) begin
            return FWD_EXMEM;
        end
        if (wb.reg_w && wb.dest == src) begin
            return FWD_MEMWB;
        end
        return FWD_NONE;
    endfunction

    always_comb begin
        fwd_a = pick_src(idex_rs);
        fwd_b = pick_src(idex_rt);
    end

endmodule

// ==== hw/decode_stage.sv ====
module decode_stage
    import isa_pkg::*, pipe_pkg::*;
(
    input  logic      clk,
    input  logic      arst_n,
    input  if_id_t    if_id,
    input  wb_t       wb,
    input  logic      stall,
    input  logic      flush_idex,
    output id_ex_t    id_ex,
    output logic      jump,
    output word_t     jump_target,
    output reg_addr_t id_rs,
    output reg_addr_t id_rt
);

    instr_u instr;
    ctrl_t  ctrl;
    word_t  rs_val;
    word_t  rt_val;
    word_t  imm;
    logic   zero_ext;
    logic   upper_ext;

    assign instr = if_id.instr;
    assign id_rs = instr.r.rs;
    assign id_rt = instr.r.rt;

    // Region of pc+4 with the word index
    assign jump_target = {if_id.pc_4[31:28], instr.j.target, 2'b00};

    reg_file u_reg_file (
        .clk     (clk),
        .arst_n  (arst_n),
        .rs_addr (id_rs),
        .rt_addr (id_rt),
        .rs_val  (rs_val),
        .rt_val  (rt_val),
        .wb      (wb)
    );

    ////////////////////
    // Decoder
    ////////////////////

    always_comb begin
        ctrl        = '0;
        ctrl.alu_op = ALU_ADD;
        zero_ext    = 1'b0;
        upper_ext   = 1'b0;
        jump        = 1'b0;
        case (instr.i.opcode)
            OP_RTYPE: begin
                ctrl.reg_w = 1'b1;
                case (instr.r.funct)
                    FN_ADDU: ctrl.alu_op = ALU_ADD;
                    FN_SUBU: ctrl.alu_op = ALU_SUB;
                    FN_AND:  ctrl.alu_op = ALU_AND;
                    FN_OR:   ctrl.alu_op = ALU_OR;
                    FN_XOR:  ctrl.alu_op = ALU_XOR;
                    FN_SLT:  ctrl.alu_op = ALU_SLT;
                    // Unknown funct and nop write nothing
                    default: ctrl.reg_w  = 1'b0;
                endcase
            end
            OP_ADDIU: begin
                ctrl.reg_w = 1'b1;
                ctrl.b_imm = 1'b1;
            end
            OP_ANDI, OP_ORI: begin
                ctrl.reg_w  = 1'b1;
                ctrl.b_imm  = 1'b1;
                ctrl.alu_op = (instr.i.opcode == OP_ANDI) ? ALU_AND : ALU_OR;
                zero_ext    = 1'b1;
            end
            OP_LUI: begin
                ctrl.reg_w  = 1'b1;
                ctrl.b_imm  = 1'b1;
                ctrl.alu_op = ALU_PASS_B;
                upper_ext   = 1'b1;
            end
            OP_LW: begin
                ctrl.reg_w = 1'b1;
                ctrl.mem_r = 1'b1;
                ctrl.b_imm = 1'b1;
            end
            OP_SW: begin
                ctrl.mem_w = 1'b1;
                ctrl.b_imm = 1'b1;
            end
            // Compare happens in EX on forwarded operands
            OP_BEQ, OP_BNE: begin
                ctrl.branch    = 1'b1;
                ctrl.branch_ne = (instr.i.opcode == OP_BNE);
            end
            OP_J: jump = 1'b1;
            default: ;
        endcase
    end

    // Immediate, sign extended unless logical or lui
    always_comb begin
        if (upper_ext) begin
            imm = {instr.i.imm, 16'h0000};
        end else if (zero_ext) begin
            imm = {16'h0000, instr.i.imm};
        end else begin
            imm = {{16{instr.i.imm[15]}}, instr.i.imm};
        end
    end

    ////////////////////
    // ID/EX
    ////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            id_ex <= '0;
        end else if (stall || flush_idex) begin
            // Bubble
            id_ex <= '0;
        end else begin
            id_ex.ctrl   <= ctrl;
            id_ex.pc_4   <= if_id.pc_4;
            id_ex.rs_val <= rs_val;
            id_ex.rt_val <= rt_val;
            id_ex.imm    <= imm;
            id_ex.rs     <= instr.r.rs;
            id_ex.rt     <= instr.r.rt;
            // rd for R-format, rt otherwise
            id_ex.dest   <= (instr.r.opcode == OP_RTYPE) ? instr.r.rd : instr.i.rt;
        end
    end

endmodule

// ==== hw/fetch_stage.sv ====
`include "cpu_config.svh"

module fetch_stage
    import isa_pkg::*, pipe_pkg::*;
(
    input  logic    clk,
    input  logic    arst_n,
    input  pc_src_e pc_src,
    input  logic    stall,
    input  logic    flush_ifid,
    input  word_t   jump_target,
    input  word_t   branch_target,
    output word_t   imem_addr,
    input  instr_u  imem_data,
    output if_id_t  if_id
);

    word_t pc;
    word_t pc_4;
    word_t pc_next;

    assign pc_4      = pc + word_t'(4);
    assign imem_addr = pc;

    // Next PC, branch and jump chosen by the control unit
    always_comb begin
        case (pc_src)
            PC_JUMP:   pc_next = jump_target;
            PC_BRANCH: pc_next = branch_target;
            default:   pc_next = pc_4;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc <= `RESET_PC;
        end else if (!stall) begin
            pc <= pc_next;
        end
    end

    ////////////////////
    // IF/ID
    ////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            if_id <= '0;
        end else if (flush_ifid) begin
            // Squash the word fetched behind a jump or taken branch
            if_id.pc_4  <= pc_4;
            if_id.instr <= INSTR_NOP;
        end else if (!stall) begin
            if_id.pc_4  <= pc_4;
            if_id.instr <= imem_data;
        end
    end

endmodule

// ==== hw/reg_file.sv ====
`include "cpu_config.svh"

module reg_file
    import pipe_pkg::*;
(
    input  logic      clk,
    input  logic      arst_n,
    input  reg_addr_t rs_addr,
    input  reg_addr_t rt_addr,
    output word_t     rs_val,
    output word_t     rt_val,
    input  wb_t       wb
);

    word_t regs [`REG_COUNT];

    // Entry 0 is never written
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.reg_w && wb.dest != '0) begin
            regs[wb.dest] <= wb.data;
        end
    end

    // Read port, a same-cycle write wins
    function automatic word_t read_port(input reg_addr_t addr);
        if (addr == '0) begin
            return '0;
        end
        if (wb.reg_w && wb.dest == addr) begin
            return wb.data;
        end
        return regs[addr];
    endfunction

    always_comb begin
        rs_val = read_port(rs_addr);
        rt_val = read_port(rt_addr);
    end

endmodule

// ==== hw/pipe_pkg.sv ====
`include "cpu_config.svh"

package pipe_pkg;

    import isa_pkg::*;

    typedef logic [`DATA_W-1:0]     word_t;
    typedef logic [`REG_ADDR_W-1:0] reg_addr_t;

    // Control bundle carried from ID into EX
    typedef struct packed {
        logic    reg_w;
        logic    mem_r;
        logic    mem_w;
        // Operand B from the immediate
        logic    b_imm;
        logic    branch;
        // Taken on inequality (bne)
        logic    branch_ne;
        alu_op_e alu_op;
    } ctrl_t;

    ////////////////////
    // Stage registers
    ////////////////////

    typedef struct packed {
        word_t  pc_4;
        instr_u instr;
    } if_id_t;

    typedef struct packed {
        ctrl_t     ctrl;
        word_t     pc_4;
        word_t     rs_val;
        word_t     rt_val;
        word_t     imm;
        reg_addr_t rs;
        reg_addr_t rt;
        reg_addr_t dest;
    } id_ex_t;

    typedef struct packed {
        logic      reg_w;
        logic      mem_r;
        logic      mem_w;
        reg_addr_t dest;
        // ALU result, doubles as the load or store address
        word_t     result;
        word_t     store_data;
    } ex_mem_t;

    // MEM/WB, also the register file write port
    typedef struct packed {
        logic      reg_w;
        reg_addr_t dest;
        word_t     data;
    } wb_t;

    ////////////////////
    // Selectors and ports
    ////////////////////

    typedef enum logic [1:0] {
        FWD_NONE,
        FWD_EXMEM,
        FWD_MEMWB
    } fwd_sel_e;

    typedef enum logic [1:0] {
        PC_SEQ,
        PC_JUMP,
        PC_BRANCH
    } pc_src_e;

    // Data memory strobes, word access only
    typedef struct packed {
        logic  re;
        logic  we;
        word_t addr;
        word_t wdata;
    } dmem_req_t;

endpackage

// ==== hw/isa_pkg.sv ====
package isa_pkg;

    ////////////////////
    // Instruction views
    ////////////////////

    // Register format
    typedef struct packed {
        logic [5:0] opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } instr_r_t;

    // Immediate format
    typedef struct packed {
        logic [5:0]  opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
    } instr_i_t;

    // Jump format, 26-bit word index
    typedef struct packed {
        logic [5:0]  opcode;
        logic [25:0] target;
    } instr_j_t;

    // One fetched word, read through whichever view fits
    typedef union packed {
        instr_r_t r;
        instr_i_t i;
        instr_j_t j;
    } instr_u;

    // sll $0,$0,0 writes nothing
    localparam instr_u INSTR_NOP = '0;

    ////////////////////
    // Codes
    ////////////////////

    typedef enum logic [5:0] {
        OP_RTYPE = 6'h00,
        OP_J     = 6'h02,
        OP_BEQ   = 6'h04,
        OP_BNE   = 6'h05,
        OP_ADDIU = 6'h09,
        OP_ANDI  = 6'h0c,
        OP_ORI   = 6'h0d,
        OP_LUI   = 6'h0f,
        OP_LW    = 6'h23,
        OP_SW    = 6'h2b
    } opcode_e;

    // R-format function field
    typedef enum logic [5:0] {
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_XOR  = 6'h26,
        FN_SLT  = 6'h2a
    } funct_e;

    // ALU operation, pass-B serves lui
    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_PASS_B
    } alu_op_e;

endpackage

// ==== hw/cpu_config.svh ====
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// Machine word, also the address width
`define DATA_W 32

// GPR index width and count
`define REG_ADDR_W 5
`define REG_COUNT 32

// First fetch address after reset
`define RESET_PC 32'h0000_0000

`endif
